// ==== rtl/frame_config.svh ====
`ifndef FRAME_CONFIG_SVH
`define FRAME_CONFIG_SVH

// OSD status word
`define FRAME_STATUS_W      64

// DDR port
`define FRAME_DDR_AW        29
`define FRAME_DDR_BEW       8
`define FRAME_BURST_W       8

// Extension port, 7 pins shared by DB15 and UART
`define FRAME_USER_W        7

// Sync offsets and the counters that apply them
`define FRAME_OFS_W         4
`define FRAME_SYNC_CNT_W    12

// OSD menu mask, a high bit hides the item
`define FRAME_MENU_W        16

// 1 moves the vertical-game item to bit 4 of the menu mask
`define FRAME_ROTATE_MENU   0

// Rotation mode value for a flipped frame buffer
`define FRAME_ROT_FLIP      2

`endif

// ==== rtl/frame_pkg.sv ====
`include "frame_config.svh"

package frame_pkg;

    // Video settings as seen in the status word
    typedef struct packed {
        logic [`FRAME_STATUS_W-41:0] rsvd_hi;
        logic [1:0]                  rot_mode;
        logic                        rsvd_37;
        logic                        shadowmask_flip;
        logic                        shadowmask_2x;
        logic [2:0]                  shadowmask;
        logic [`FRAME_OFS_W-1:0]     voffset;
        logic [`FRAME_OFS_W-1:0]     hoffset;
        logic [3:0]                  hsize_scale;
        logic                        hsize_enable;
        logic [18:0]                 rsvd_lo;
    } status_video_t;

    // User-port mode bits; uart_en overlaps rot_mode[0]
    typedef struct packed {
        logic [`FRAME_STATUS_W-40:0] rsvd_hi;
        logic                        uart_en;
        logic                        db15_en;
        logic [36:0]                 rsvd_lo;
    } status_io_t;

    typedef union packed {
        status_video_t video_view;
        status_io_t    io_view;
    } status_word_u;

    typedef struct packed {
        logic [`FRAME_OFS_W-1:0] hoffset;
        logic [`FRAME_OFS_W-1:0] voffset;
        logic                    hsize_enable;
        logic [3:0]              hsize_scale;
        logic [2:0]              shadowmask;
        logic                    shadowmask_2x;
        logic                    shadowmask_rot;
        logic                    framebuf_flip;
    } video_cfg_t;

    typedef struct packed {
        logic [`FRAME_BURST_W-1:0]  burstcnt;
        logic [`FRAME_DDR_AW-1:0]   addr;
        logic                       rd;
        logic                       we;
        logic [`FRAME_DDR_BEW-1:0]  be;
    } ddr_req_t;

    typedef enum logic {
        OWN_ROT  = 1'b0,
        OWN_LOAD = 1'b1
    } ddr_owner_e;

endpackage

// ==== rtl/osd_status_decode.sv ====
`timescale 1ns/1ps
`include "frame_config.svh"

module osd_status_decode
    import frame_pkg::*;
(
    input  logic                      clk_sys,
    input  logic                      rst,
    input  status_word_u              status,
    input  logic                      core_vertical,
    input  logic                      direct_video,
    input  logic [`FRAME_USER_W-1:0]  user_in,
    input  logic [`FRAME_USER_W-1:0]  joy_out,
    input  logic                      uart_tx,
    input  logic                      game_tx,
    output video_cfg_t                video_cfg,
    output logic [`FRAME_MENU_W-1:0]  menumask,
    output logic [`FRAME_USER_W-1:0]  user_out,
    output logic                      game_rx
);

    localparam logic [1:0] ROT_FLIP    = `FRAME_ROT_FLIP;
    localparam bit         ROTATE_MENU = `FRAME_ROTATE_MENU;

    logic                     db15_en;
    logic                     uart_en;
    logic [`FRAME_MENU_W-1:0] menu_nxt;

    assign db15_en = status.io_view.db15_en;
    assign uart_en = status.io_view.uart_en;

    // Hidden items are high
    always_comb begin
        menu_nxt    = '0;
        menu_nxt[4] = ROTATE_MENU ? ~core_vertical : 1'b1;
        menu_nxt[3] = status.video_view.shadowmask == 3'd0;
        menu_nxt[2] = ~status.video_view.hsize_enable;
        menu_nxt[1] = ROTATE_MENU ? 1'b1 : ~core_vertical;
        menu_nxt[0] = direct_video;
    end

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            video_cfg <= '0;
            menumask  <= '0;
        end else begin
            video_cfg.hoffset        <= status.video_view.hoffset;
            video_cfg.voffset        <= status.video_view.voffset;
            video_cfg.hsize_enable   <= status.video_view.hsize_enable;
            video_cfg.hsize_scale    <= status.video_view.hsize_scale;
            video_cfg.shadowmask     <= status.video_view.shadowmask;
            video_cfg.shadowmask_2x  <= status.video_view.shadowmask_2x;
            // Mask follows the screen orientation
            video_cfg.shadowmask_rot <= core_vertical ^ status.video_view.shadowmask_flip;
            video_cfg.framebuf_flip  <= status.video_view.rot_mode == ROT_FLIP;
            menumask                 <= menu_nxt;
        end
    end

    // DB15 adapter has priority over the UART
    always_comb begin
        if (db15_en) begin
            user_out = joy_out;
        end else if (uart_en) begin
            user_out = {{(`FRAME_USER_W-1){1'b0}}, uart_tx & game_tx};
        end else begin
            user_out = '1;
        end
    end

    // Idle line when the UART is off
    assign game_rx = ~uart_en | user_in[1];

endmodule

// ==== rtl/sync_offset_timer.sv ====
`timescale 1ns/1ps
`include "frame_config.svh"

module sync_offset_timer (
    input  logic                     clk_sys,
    input  logic                     rst,
    input  logic                     pxl_cen,
    input  logic                     hs,
    input  logic                     vs,
    input  logic [`FRAME_OFS_W-1:0]  hoffset,
    input  logic [`FRAME_OFS_W-1:0]  voffset,
    output logic                     hs_out,
    output logic                     vs_out
);

    localparam int CNT_W = `FRAME_SYNC_CNT_W;

    logic [1:0] sync_q;
    logic       line_tick;

    // Vertical channel counts hs rising edges
    assign line_tick = chan[0].rise;

    // Channel 0 is hs on pixels, channel 1 is vs on lines
    for (genvar ch = 0; ch < 2; ch++) begin : chan
        logic             tick;
        logic             sig;
        logic [CNT_W-1:0] ofs;
        logic             sig_l;
        logic             rise;
        logic             fall;
        logic [CNT_W-1:0] pos;
        logic [CNT_W-1:0] pos_now;
        logic [CNT_W-1:0] fall_tgt;
        logic             rise_pend;
        logic             fall_pend;
        logic             set_out;
        logic             clr_out;
        logic             out_q;

        assign tick = (ch == 0) ? pxl_cen : line_tick;
        assign sig  = (ch == 0) ? hs : vs;
        assign ofs  = CNT_W'((ch == 0) ? hoffset : voffset);
        assign rise = tick & sig & ~sig_l;
        assign fall = tick & ~sig & sig_l;

        // Position restarts at 0 on the input rising edge
        assign pos_now = rise ? '0 : pos + 1'b1;
        assign set_out = (rise | rise_pend) && (pos_now == ofs);
        assign clr_out = (fall && ofs == '0) || (fall_pend && pos_now == fall_tgt);

        always_ff @(posedge clk_sys) begin
            if (rst) begin
                sig_l     <= 1'b0;
                pos       <= '0;
                fall_tgt  <= '0;
                rise_pend <= 1'b0;
                fall_pend <= 1'b0;
                out_q     <= 1'b0;
            end else if (tick) begin
                sig_l <= sig;
                pos   <= pos_now;
                if (set_out) begin
                    out_q     <= 1'b1;
                    rise_pend <= 1'b0;
                end else if (rise) begin
                    rise_pend <= 1'b1;
                end
                // Remember where the delayed fall lands
                if (fall) begin
                    fall_tgt  <= pos_now + ofs;
                    fall_pend <= ofs != '0;
                end else if (clr_out) begin
                    fall_pend <= 1'b0;
                end
                if (clr_out) begin
                    out_q <= 1'b0;
                end
            end
        end

        assign sync_q[ch] = out_q;
    end

    assign hs_out = sync_q[0];
    assign vs_out = sync_q[1];

    // Delayed rise must land before the hs pulse ends
    assert property (@(posedge clk_sys) disable iff (rst)
        (chan[0].fall && chan[0].rise_pend) |-> chan[0].set_out)
        else $error("hs pulse shorter than hoffset");

endmodule

// ==== rtl/ddr_owner_fsm.sv ====
`timescale 1ns/1ps
`include "frame_config.svh"

module ddr_owner_fsm
    import frame_pkg::*;
(
    input  logic       clk_sys,
    input  logic       rst,
    input  logic       downloading,
    input  logic       ddr_busy,
    input  logic       ddr_dout_ready,
    input  ddr_req_t   ddrld_req,
    input  ddr_req_t   rot_req,
    output ddr_owner_e owner
);

    // Room for a few back-to-back loader bursts
    localparam int PEND_W = `FRAME_BURST_W + 2;

    ddr_owner_e        owner_nxt;
    logic [PEND_W-1:0] pend_cnt;
    logic              ld_accept;
    logic              beat_in;
    logic              rot_idle;

    assign rot_idle  = ~rot_req.rd & ~rot_req.we;
    assign ld_accept = ddrld_req.rd && owner == OWN_LOAD && !ddr_busy;
    assign beat_in   = ddr_dout_ready && owner == OWN_LOAD;

    always_comb begin
        owner_nxt = owner;
        case (owner)
            OWN_ROT: begin
                if (downloading && !ddr_busy && rot_idle) begin
                    owner_nxt = OWN_LOAD;
                end
            end
            OWN_LOAD: begin
                // Wait for every read beat before giving DDR back
                if (!downloading && pend_cnt == '0 && !ld_accept) begin
                    owner_nxt = OWN_ROT;
                end
            end
            default: owner_nxt = OWN_ROT;
        endcase
    end

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            owner    <= OWN_ROT;
            pend_cnt <= '0;
        end else begin
            owner    <= owner_nxt;
            pend_cnt <= pend_cnt
                      + (ld_accept ? PEND_W'(ddrld_req.burstcnt) : '0)
                      - PEND_W'(beat_in);
        end
    end

    assert property (@(posedge clk_sys) disable iff (rst)
        beat_in |-> (pend_cnt != '0))
        else $error("Read beat arrived with no loader burst outstanding");

endmodule

// ==== rtl/ddr_req_mux.sv ====
`timescale 1ns/1ps

module ddr_req_mux
    import frame_pkg::*;
(
    input  ddr_owner_e owner,
    input  ddr_req_t   ddrld_req,
    input  ddr_req_t   rot_req,
    input  logic       ddr_busy,
    output ddr_req_t   ddr_req,
    output logic       ddrld_busy,
    output logic       rot_busy
);

    // Non-owner sees busy so it holds its strobe
    always_comb begin
        case (owner)
            OWN_LOAD: begin
                ddr_req    = ddrld_req;
                ddrld_busy = ddr_busy;
                rot_busy   = 1'b1;
            end
            default: begin
                ddr_req    = rot_req;
                ddrld_busy = 1'b1;
                rot_busy   = ddr_busy;
            end
        endcase
        assert (!(ddr_req.rd && ddr_req.we))
            else $error("DDR read and write strobes high together");
    end

endmodule

// ==== rtl/frame_io_top.sv ====
`timescale 1ns/1ps
`include "frame_config.svh"

module frame_io_top
    import frame_pkg::*;
(
    input  logic                      clk_sys,
    input  logic                      rst,
    // OSD status and core mode
    input  status_word_u              status,
    input  logic                      core_vertical,
    input  logic                      direct_video,
    // Extension port and UART
    input  logic [`FRAME_USER_W-1:0]  user_in,
    input  logic [`FRAME_USER_W-1:0]  joy_out,
    input  logic                      uart_tx,
    input  logic                      game_tx,
    output logic [`FRAME_USER_W-1:0]  user_out,
    output logic                      game_rx,
    // Video
    input  logic                      pxl_cen,
    input  logic                      hs,
    input  logic                      vs,
    output logic                      hs_out,
    output logic                      vs_out,
    output video_cfg_t                video_cfg,
    output logic [`FRAME_MENU_W-1:0]  menumask,
    // DDR
    input  logic                      downloading,
    input  ddr_req_t                  ddrld_req,
    input  ddr_req_t                  rot_req,
    input  logic                      ddr_busy,
    input  logic                      ddr_dout_ready,
    output ddr_req_t                  ddr_req,
    output logic                      ddrld_busy,
    output logic                      rot_busy
);

    ddr_owner_e owner;

    osd_status_decode u_decode (
        .clk_sys       ( clk_sys       ),
        .rst           ( rst           ),
        .status        ( status        ),
        .core_vertical ( core_vertical ),
        .direct_video  ( direct_video  ),
        .user_in       ( user_in       ),
        .joy_out       ( joy_out       ),
        .uart_tx       ( uart_tx       ),
        .game_tx       ( game_tx       ),
        .video_cfg     ( video_cfg     ),
        .menumask      ( menumask      ),
        .user_out      ( user_out      ),
        .game_rx       ( game_rx       )
    );

    // Offsets come from the registered settings
    sync_offset_timer u_sync (
        .clk_sys ( clk_sys           ),
        .rst     ( rst               ),
        .pxl_cen ( pxl_cen           ),
        .hs      ( hs                ),
        .vs      ( vs                ),
        .hoffset ( video_cfg.hoffset ),
        .voffset ( video_cfg.voffset ),
        .hs_out  ( hs_out            ),
        .vs_out  ( vs_out            )
    );

    ddr_owner_fsm u_owner (
        .clk_sys        ( clk_sys        ),
        .rst            ( rst            ),
        .downloading    ( downloading    ),
        .ddr_busy       ( ddr_busy       ),
        .ddr_dout_ready ( ddr_dout_ready ),
        .ddrld_req      ( ddrld_req      ),
        .rot_req        ( rot_req        ),
        .owner          ( owner          )
    );

    ddr_req_mux u_mux (
        .owner      ( owner      ),
        .ddrld_req  ( ddrld_req  ),
        .rot_req    ( rot_req    ),
        .ddr_busy   ( ddr_busy   ),
        .ddr_req    ( ddr_req    ),
        .ddrld_busy ( ddrld_busy ),
        .rot_busy   ( rot_busy   )
    );

endmodule

// ==== verif/tb_frame_io.sv ====
`timescale 1ns/1ps
`include "frame_config.svh"

module tb_frame_io
    import frame_pkg::*;
();

    localparam int DEC_ROWS    = 16;
    localparam int DDR_ROWS    = 17;
    localparam int SYNC_CLKS   = 640;
    localparam int LINE_TICKS  = 16;
    localparam int FRAME_LINES = 8;
    localparam int SYNC_HOFS   = 3;
    localparam int SYNC_VOFS   = 2;
    localparam int CYCLE_LIMIT = 2 * (DEC_ROWS + DDR_ROWS) + SYNC_CLKS;

    typedef struct packed {
        logic [`FRAME_STATUS_W-1:0] status;
        logic                       core_vertical;
        logic                       direct_video;
        logic [`FRAME_USER_W-1:0]   user_in;
        logic [`FRAME_USER_W-1:0]   joy_out;
        logic                       uart_tx;
        logic                       game_tx;
        video_cfg_t                 cfg;
        logic [`FRAME_MENU_W-1:0]   menumask;
        logic [`FRAME_USER_W-1:0]   user_out;
        logic                       game_rx;
    } dec_row_t;

    typedef struct packed {
        logic downloading;
        logic ddr_busy;
        logic dout_ready;
        logic ld_rd;
        logic rot_rd;
        logic rot_we;
        logic to_loader;
    } ddr_row_t;

    logic                     clk_sys;
    logic                     rst;
    status_word_u             status;
    logic                     core_vertical;
    logic                     direct_video;
    logic [`FRAME_USER_W-1:0] user_in;
    logic [`FRAME_USER_W-1:0] joy_out;
    logic                     uart_tx;
    logic                     game_tx;
    logic [`FRAME_USER_W-1:0] user_out;
    logic                     game_rx;
    logic                     pxl_cen;
    logic                     hs;
    logic                     vs;
    logic                     hs_out;
    logic                     vs_out;
    video_cfg_t               video_cfg;
    logic [`FRAME_MENU_W-1:0] menumask;
    logic                     downloading;
    ddr_req_t                 ddrld_req;
    ddr_req_t                 rot_req;
    logic                     ddr_busy;
    logic                     ddr_dout_ready;
    ddr_req_t                 ddr_req;
    logic                     ddrld_busy;
    logic                     rot_busy;

    integer   seed;
    int       cycle_cnt = 0;
    dec_row_t dec_tab [DEC_ROWS];
    ddr_row_t ddr_tab [DDR_ROWS];

    frame_io_top uut (.*);

    initial begin
        clk_sys = 1'b0;
        forever #2 clk_sys = ~clk_sys;
    end

    always @(posedge clk_sys) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            report_failure($sformatf("Timeout: run went past %0d cycles", CYCLE_LIMIT));
        end
    end

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Result: FAILED");
        $fatal(1, "Run aborted");
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        assert (got === exp) else begin
            $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
            $display("Result: FAILED");
            $fatal(1, "Stopped at the first mismatch");
        end
    endtask

    // Field positions of the OSD status word
    function automatic video_cfg_t predict_cfg(input logic [63:0] s, input logic vert);
        video_cfg_t c;
        c.hoffset        = s[27:24];
        c.voffset        = s[31:28];
        c.hsize_enable   = s[19];
        c.hsize_scale    = s[23:20];
        c.shadowmask     = s[34:32];
        c.shadowmask_2x  = s[35];
        c.shadowmask_rot = vert ^ s[36];
        c.framebuf_flip  = s[39:38] == 2'(`FRAME_ROT_FLIP);
        return c;
    endfunction

    function automatic logic [15:0] predict_menu(input logic [63:0] s, input logic vert,
                                                 input logic dv);
        logic [15:0] m;
        m    = '0;
        m[3] = s[34:32] == 3'd0;
        m[2] = ~s[19];
        m[0] = dv;
        // One item hidden, the other shown for vertical games only
        if (`FRAME_ROTATE_MENU != 0) begin
            m[4] = ~vert;
            m[1] = 1'b1;
        end else begin
            m[4] = 1'b1;
            m[1] = ~vert;
        end
        return m;
    endfunction

    task automatic build_tables();
        logic [63:0] s;
        int          i;
        for (i = 0; i < DEC_ROWS; i++) begin
            s = {$random(seed), $random(seed)};
            // Walk bits 39:37 so every port mode and rot_mode 2 show up
            s[39:37] = 3'(i);
            if (i % 5 == 0) begin
                s[34:32] = 3'd0;
            end
            dec_tab[i].status        = s;
            dec_tab[i].core_vertical = 1'($random(seed));
            dec_tab[i].direct_video  = 1'($random(seed));
            dec_tab[i].user_in       = 7'($random(seed));
            dec_tab[i].joy_out       = 7'($random(seed));
            dec_tab[i].uart_tx       = 1'($random(seed));
            dec_tab[i].game_tx       = 1'($random(seed));
            dec_tab[i].cfg           = predict_cfg(s, dec_tab[i].core_vertical);
            dec_tab[i].menumask      = predict_menu(s, dec_tab[i].core_vertical,
                                                    dec_tab[i].direct_video);
            if (s[37]) begin
                dec_tab[i].user_out = dec_tab[i].joy_out;
            end else if (s[38]) begin
                dec_tab[i].user_out = {6'd0, dec_tab[i].uart_tx & dec_tab[i].game_tx};
            end else begin
                dec_tab[i].user_out = 7'h7f;
            end
            dec_tab[i].game_rx = ~s[38] | dec_tab[i].user_in[1];
        end
        // dl busy rdy ld_rd rot_rd rot_we | owner is loader after the edge
        ddr_tab[0]  = 7'b0_0_0_0_1_0_0;
        ddr_tab[1]  = 7'b1_1_0_0_0_0_0;
        ddr_tab[2]  = 7'b1_0_0_0_1_0_0;
        ddr_tab[3]  = 7'b1_0_0_0_0_1_0;
        ddr_tab[4]  = 7'b1_0_0_0_0_0_1;
        ddr_tab[5]  = 7'b1_1_0_1_0_0_1;
        ddr_tab[6]  = 7'b1_0_0_1_0_0_1;
        ddr_tab[7]  = 7'b1_0_1_0_0_0_1;
        ddr_tab[8]  = 7'b1_0_1_0_0_0_1;
        ddr_tab[9]  = 7'b0_0_0_0_0_0_1;
        ddr_tab[10] = 7'b0_0_1_0_1_0_1;
        ddr_tab[11] = 7'b0_0_1_0_1_0_1;
        ddr_tab[12] = 7'b1_0_0_0_0_0_1;
        ddr_tab[13] = 7'b0_0_0_0_1_0_0;
        ddr_tab[14] = 7'b0_1_0_0_1_0_0;
        ddr_tab[15] = 7'b1_0_0_0_0_0_1;
        ddr_tab[16] = 7'b0_0_0_0_0_0_0;
    endtask

    task automatic run_decode();
        int i;
        for (i = 0; i < DEC_ROWS; i++) begin
            status        = dec_tab[i].status;
            core_vertical = dec_tab[i].core_vertical;
            direct_video  = dec_tab[i].direct_video;
            user_in       = dec_tab[i].user_in;
            joy_out       = dec_tab[i].joy_out;
            uart_tx       = dec_tab[i].uart_tx;
            game_tx       = dec_tab[i].game_tx;
            @(negedge clk_sys);
            check_value("video_cfg", 64'(video_cfg), 64'(dec_tab[i].cfg));
            check_value("menumask", 64'(menumask), 64'(dec_tab[i].menumask));
            check_value("user_out", 64'(user_out), 64'(dec_tab[i].user_out));
            check_value("game_rx", 64'(game_rx), 64'(dec_tab[i].game_rx));
        end
    endtask

    // Outputs repeat the inputs as sampled offset ticks or lines earlier
    task automatic run_sync();
        logic hs_hist [$];
        logic vs_hist [$];
        logic hs_tick_l;
        logic exp_hs;
        logic exp_vs;
        int   px;
        int   ln;
        int   c;
        status                    = '0;
        status.video_view.hoffset = 4'(SYNC_HOFS);
        status.video_view.voffset = 4'(SYNC_VOFS);
        repeat (2) @(negedge clk_sys);
        hs_tick_l = 1'b0;
        exp_hs    = 1'b0;
        exp_vs    = 1'b0;
        px        = 0;
        ln        = 0;
        for (c = 0; c < SYNC_CLKS; c++) begin
            pxl_cen = c % 2 == 0;
            hs      = px >= 10 && px < 15;
            vs      = ln >= 2 && ln < 5;
            if (pxl_cen) begin
                hs_hist.push_back(hs);
                if (hs_hist.size() > SYNC_HOFS) begin
                    exp_hs = hs_hist[hs_hist.size() - 1 - SYNC_HOFS];
                end
                if (hs && !hs_tick_l) begin
                    vs_hist.push_back(vs);
                    if (vs_hist.size() > SYNC_VOFS) begin
                        exp_vs = vs_hist[vs_hist.size() - 1 - SYNC_VOFS];
                    end
                end
                hs_tick_l = hs;
                px        = (px + 1) % LINE_TICKS;
                if (px == 0) begin
                    ln = (ln + 1) % FRAME_LINES;
                end
            end
            @(negedge clk_sys);
            check_value("hs_out", 64'(hs_out), 64'(exp_hs));
            check_value("vs_out", 64'(vs_out), 64'(exp_vs));
        end
        pxl_cen = 1'b0;
    endtask

    task automatic run_ddr();
        ddr_req_t exp_req;
        logic     exp_ld_busy;
        logic     exp_rot_busy;
        int       i;
        for (i = 0; i < DDR_ROWS; i++) begin
            downloading    = ddr_tab[i].downloading;
            ddr_busy       = ddr_tab[i].ddr_busy;
            ddr_dout_ready = ddr_tab[i].dout_ready;
            ddrld_req.rd   = ddr_tab[i].ld_rd;
            rot_req.rd     = ddr_tab[i].rot_rd;
            rot_req.we     = ddr_tab[i].rot_we;
            @(negedge clk_sys);
            // Non-owner is held off with busy high
            if (ddr_tab[i].to_loader) begin
                exp_req      = ddrld_req;
                exp_ld_busy  = ddr_busy;
                exp_rot_busy = 1'b1;
            end else begin
                exp_req      = rot_req;
                exp_ld_busy  = 1'b1;
                exp_rot_busy = ddr_busy;
            end
            check_value("ddr_req", 64'(ddr_req), 64'(exp_req));
            check_value("ddrld_busy", 64'(ddrld_busy), 64'(exp_ld_busy));
            check_value("rot_busy", 64'(rot_busy), 64'(exp_rot_busy));
        end
    endtask

    initial begin
        seed           = 16;
        rst            = 1'b1;
        status         = '0;
        core_vertical  = 1'b0;
        direct_video   = 1'b0;
        user_in        = '0;
        joy_out        = '0;
        uart_tx        = 1'b0;
        game_tx        = 1'b0;
        pxl_cen        = 1'b0;
        hs             = 1'b0;
        vs             = 1'b0;
        downloading    = 1'b0;
        ddr_busy       = 1'b0;
        ddr_dout_ready = 1'b0;
        ddrld_req      = '0;
        rot_req        = '0;
        ddrld_req.burstcnt = 8'd4;
        ddrld_req.addr     = 29'($random(seed));
        ddrld_req.be       = 8'($random(seed));
        rot_req.burstcnt   = 8'($random(seed));
        rot_req.addr       = 29'($random(seed));
        rot_req.be         = 8'($random(seed));
        build_tables();
        repeat (2) @(posedge clk_sys);
        @(negedge clk_sys);
        check_value("video_cfg", 64'(video_cfg), 64'd0);
        check_value("menumask", 64'(menumask), 64'd0);
        check_value("hs_out", 64'(hs_out), 64'd0);
        check_value("vs_out", 64'(vs_out), 64'd0);
        check_value("ddr_req", 64'(ddr_req), 64'(rot_req));
        rst = 1'b0;
        run_decode();
        run_sync();
        run_ddr();
        $display("Result: PASSED");
        $finish;
    end

endmodule

// ==== flist.f ====
+incdir+rtl
rtl/frame_pkg.sv
rtl/osd_status_decode.sv
rtl/sync_offset_timer.sv
rtl/ddr_owner_fsm.sv
rtl/ddr_req_mux.sv
rtl/frame_io_top.sv
verif/tb_frame_io.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Compile with Verilator and run; pass only when the pass line is printed
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f flist.f --top-module tb_frame_io \
    --Mdir obj_dir -o sim_frame_io \
    && ./obj_dir/sim_frame_io | tee /dev/stderr | grep -q "Result: PASSED" \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
